//--- logic/cab_inputs.sv
/*
 * Cabinet input merge
 * ORs key, mouse and joystick buttons into the
 * active-low cabinet lines and holds the DIP byte
 */

`timescale 1ns/100ps

module cab_inputs (
	input  logic           CLK_48M,
	input  logic           rst_n,
	host_evt_if.dst        ev,
	input  ctrl_pkg::btn_t keys,
	input  ctrl_pkg::joy_t joy,
	output logic           btn_shot_n,
	output logic           start1_n,
	output logic           start2_n,
	output logic           coin1_n,
	output logic           coin2_n,
	output logic           service_n,
	output logic [7:0]     dip_sw
);
	import ctrl_pkg::*;

	logic [1:0] mouse_btn; // Mask from last mouse event

	////////////////////
	// Event state
	////////////////////
	always_ff @(posedge CLK_48M) begin
		if (!rst_n) begin
			mouse_btn <= 2'b00;
			dip_sw    <= 8'hFF;                 // Host byte of zero
		end else begin
			if (ev.mouse_stb)
				mouse_btn <= ev.data[1:0];
			if (ev.dip_stb)
				dip_sw <= ~ev.data[7:0];        // Game expects active low
		end
	end

	////////////////////
	// Cabinet lines
	////////////////////
	always_ff @(posedge CLK_48M) begin
		if (!rst_n) begin
			btn_shot_n <= 1'b1;
			start1_n   <= 1'b1;
			start2_n   <= 1'b1;
			coin1_n    <= 1'b1;
			coin2_n    <= 1'b1;
			service_n  <= 1'b1;
		end else begin
			btn_shot_n <= ~(keys[BTN_FIRE] | joy[JOY_FIRE] | (|mouse_btn)); // Either mouse button
			start1_n   <= ~(keys[BTN_START1] | joy[JOY_START1]);
			start2_n   <= ~(keys[BTN_START2] | joy[JOY_START2]);
			coin1_n    <= ~(keys[BTN_COIN1] | joy[JOY_COIN1]);
			coin2_n    <= ~keys[BTN_COIN2];     // Keyboard only
			service_n  <= ~keys[BTN_SERVICE];
		end
	end

endmodule

//--- logic/ctrl_pkg.sv
/*
 * Player control shared definitions
 * Event kinds, payload fields, cabinet key codes,
 * joystick bit positions and spinner step timing
 */

package ctrl_pkg;

	//////////////////////
	// Host events
	//////////////////////
	typedef logic [1:0] evt_kind_t;
	typedef logic [15:0] evt_data_t;

	localparam evt_kind_t EVT_KEY   = 2'd0;
	localparam evt_kind_t EVT_MOUSE = 2'd1;
	localparam evt_kind_t EVT_DIP   = 2'd2; // Kind 3 acked, no strobe

	localparam int KEY_PRESSED_BIT = 8; // Key payload, 1 = make

	//////////////////////
	// Keyboard and buttons
	//////////////////////
	typedef logic [7:0] scan_code_t;
	typedef logic [5:0] btn_t;

	localparam scan_code_t KEY_START1  = 8'h16; // 1
	localparam scan_code_t KEY_START2  = 8'h1E; // 2
	localparam scan_code_t KEY_COIN1   = 8'h2E; // 5
	localparam scan_code_t KEY_COIN2   = 8'h36; // 6
	localparam scan_code_t KEY_SERVICE = 8'h46; // 9
	localparam scan_code_t KEY_FIRE    = 8'h29; // Space

	localparam int BTN_FIRE    = 0;
	localparam int BTN_START1  = 1;
	localparam int BTN_START2  = 2;
	localparam int BTN_COIN1   = 3;
	localparam int BTN_COIN2   = 4;
	localparam int BTN_SERVICE = 5;

	// Host joystick word, active high
	typedef logic [9:0] joy_t;

	localparam int JOY_FIRE   = 4;
	localparam int JOY_START1 = 6;
	localparam int JOY_COIN1  = 7;
	localparam int JOY_START2 = 8;

	//////////////////////
	// Spinner
	//////////////////////
	typedef logic signed [11:0] spin_pos_t;
	typedef logic signed [7:0] mouse_delta_t;
	typedef logic [1:0] quad_t;

	localparam quad_t QUAD_RESET = 2'd3;
	localparam int SPIN_STEP_CYCLES = 12000;                 // 250 us at 48 MHz
	localparam int SPIN_CNT_W = $clog2(SPIN_STEP_CYCLES);

endpackage

//--- logic/ctrl_top.sv
/*
 * Player control front end
 * Host event receiver feeding the key decoder,
 * cabinet input merge and spinner emulation
 */

`timescale 1ns/100ps

module ctrl_top (
	input  logic                CLK_48M,
	input  logic                rst_n,
	input  logic                evt_req,
	input  ctrl_pkg::evt_kind_t evt_kind,
	input  ctrl_pkg::evt_data_t evt_data,
	output logic                evt_ack,
	input  ctrl_pkg::joy_t      joy,
	output logic                btn_shot_n,
	output logic                start1_n,
	output logic                start2_n,
	output logic                coin1_n,
	output logic                coin2_n,
	output logic                service_n,
	output logic [7:0]          dip_sw,
	output ctrl_pkg::quad_t     quad
);
	import ctrl_pkg::*;

	host_evt_if ev ();   // Strobes to all consumers
	btn_t       keys;    // Keyboard button state

	host_event_rx u_host_event_rx (
		.CLK_48M  (CLK_48M),
		.rst_n    (rst_n),
		.evt_req  (evt_req),
		.evt_kind (evt_kind),
		.evt_data (evt_data),
		.evt_ack  (evt_ack),
		.ev       (ev.src)
	);

	key_decoder u_key_decoder (
		.CLK_48M (CLK_48M),
		.rst_n   (rst_n),
		.ev      (ev.dst),
		.keys    (keys)
	);

	cab_inputs u_cab_inputs (
		.CLK_48M    (CLK_48M),
		.rst_n      (rst_n),
		.ev         (ev.dst),
		.keys       (keys),
		.joy        (joy),
		.btn_shot_n (btn_shot_n),
		.start1_n   (start1_n),
		.start2_n   (start2_n),
		.coin1_n    (coin1_n),
		.coin2_n    (coin2_n),
		.service_n  (service_n),
		.dip_sw     (dip_sw)
	);

	spinner_quad u_spinner_quad (
		.CLK_48M (CLK_48M),
		.rst_n   (rst_n),
		.ev      (ev.dst),
		.quad    (quad)
	);

endmodule

//--- logic/host_event_rx.sv
/*
 * Host event receiver
 * Four-phase req/ack handshake, one registered strobe
 * per accepted event plus the latched payload
 */

`timescale 1ns/100ps

// Strobes and payload from the receiver to its consumers
interface host_evt_if;
	import ctrl_pkg::*;

	logic      key_stb;
	logic      mouse_stb;
	logic      dip_stb;
	evt_data_t data;     // Valid with any strobe

	modport src (output key_stb, mouse_stb, dip_stb, data);
	modport dst (input key_stb, mouse_stb, dip_stb, data);
endinterface

module host_event_rx (
	input  logic                CLK_48M,
	input  logic                rst_n,
	input  logic                evt_req,
	input  ctrl_pkg::evt_kind_t evt_kind,
	input  ctrl_pkg::evt_data_t evt_data,
	output logic                evt_ack,
	host_evt_if.src             ev
);
	import ctrl_pkg::*;

	typedef enum logic {
		ST_IDLE,  // Waiting for req
		ST_ACKED  // Ack high, waiting for req to drop
	} hs_state_t;

	hs_state_t state;

	assign evt_ack = (state == ST_ACKED); // Straight from the state flop

	////////////////////
	// Handshake FSM
	////////////////////
	always_ff @(posedge CLK_48M) begin
		if (!rst_n) begin
			state        <= ST_IDLE;
			ev.key_stb   <= 1'b0;
			ev.mouse_stb <= 1'b0;
			ev.dip_stb   <= 1'b0;
		end else begin
			ev.key_stb   <= 1'b0; // Strobes last one cycle
			ev.mouse_stb <= 1'b0;
			ev.dip_stb   <= 1'b0;
			case (state)
				ST_IDLE: if (evt_req) begin
					state        <= ST_ACKED;
					ev.key_stb   <= (evt_kind == EVT_KEY);
					ev.mouse_stb <= (evt_kind == EVT_MOUSE);
					ev.dip_stb   <= (evt_kind == EVT_DIP);
				end
				default: if (!evt_req)
					state <= ST_IDLE; // Ack drops on this edge
			endcase
		end
	end

	// Payload captured with the request
	always_ff @(posedge CLK_48M) begin
		if (state == ST_IDLE && evt_req)
			ev.data <= evt_data;
	end

endmodule

//--- logic/key_decoder.sv
/*
 * Cabinet key decoder
 * Tracks make/break of the mapped scan codes
 */

`timescale 1ns/100ps

module key_decoder (
	input  logic           CLK_48M,
	input  logic           rst_n,
	host_evt_if.dst        ev,
	output ctrl_pkg::btn_t keys
);
	import ctrl_pkg::*;

	scan_code_t code;
	logic       pressed;

	assign code    = ev.data[7:0];
	assign pressed = ev.data[KEY_PRESSED_BIT];

	////////////////////
	// Pressed state
	////////////////////
	always_ff @(posedge CLK_48M) begin
		if (!rst_n) begin
			keys <= '0; // All released
		end else if (ev.key_stb) begin
			case (code)
				KEY_FIRE:    keys[BTN_FIRE]    <= pressed;
				KEY_START1:  keys[BTN_START1]  <= pressed;
				KEY_START2:  keys[BTN_START2]  <= pressed;
				KEY_COIN1:   keys[BTN_COIN1]   <= pressed;
				KEY_COIN2:   keys[BTN_COIN2]   <= pressed;
				KEY_SERVICE: keys[BTN_SERVICE] <= pressed;
				default: ; // Unmapped code ignored
			endcase
		end
	end

endmodule

//--- logic/spinner_quad.sv
/*
 * Mouse spinner emulation
 * Sums mouse deltas into a position and drains it
 * to zero as AB quadrature steps on a fixed timer
 */

`timescale 1ns/100ps

module spinner_quad (
	input  logic            CLK_48M,
	input  logic            rst_n,
	host_evt_if.dst         ev,
	output ctrl_pkg::quad_t quad
);
	import ctrl_pkg::*;

	spin_pos_t              pos;       // Pending steps, signed
	logic [SPIN_CNT_W-1:0]  tick_cnt;
	logic                   tick;
	logic                   step;
	mouse_delta_t           delta;
	spin_pos_t              add_val;
	spin_pos_t              step_val;

	// One AB transition, forward is 00 10 11 01
	function automatic quad_t quad_next(input quad_t q, input logic rev);
		quad_t n;
		if (!rev) begin
			case (q)
				2'b00:   n = 2'b10;
				2'b10:   n = 2'b11;
				2'b11:   n = 2'b01;
				default: n = 2'b00;
			endcase
		end else begin
			case (q)
				2'b00:   n = 2'b01;
				2'b01:   n = 2'b11;
				2'b11:   n = 2'b10;
				default: n = 2'b00;
			endcase
		end
		return n;
	endfunction

	////////////////////
	// Step timer
	////////////////////
	always_ff @(posedge CLK_48M) begin
		if (!rst_n)
			tick_cnt <= '0;
		else if (tick)
			tick_cnt <= '0;
		else
			tick_cnt <= tick_cnt + 1'b1; // Free running
	end

	assign tick = (tick_cnt == SPIN_CNT_W'(SPIN_STEP_CYCLES - 1));
	assign step = tick && (pos != '0);

	////////////////////
	// Position
	////////////////////
	assign delta = ev.data[15:8];

	always_comb begin
		add_val  = '0;
		step_val = '0;
		if (ev.mouse_stb && (pos[11] == pos[10]))
			add_val = {{4{delta[7]}}, delta}; // Dropped near the ends, no wrap
		if (step)
			step_val = pos[11] ? spin_pos_t'(1) : spin_pos_t'(-1); // Toward zero
	end

	always_ff @(posedge CLK_48M) begin
		if (!rst_n) begin
			pos  <= '0;
			quad <= QUAD_RESET;
		end else begin
			pos <= pos + add_val + step_val;
			if (step)
				quad <= quad_next(quad, pos[11]); // Negative runs backwards
		end
	end

endmodule

//--- tb/ctrl_asserts.sv
/*
 * Handshake and quadrature checks
 * Bound into the event receiver and the spinner
 */

`timescale 1ns/100ps

module ctrl_asserts (
	input logic            clk,
	input logic            rst_n,
	input logic            req,
	input logic            ack,
	input logic [2:0]      stb,  // key, mouse, dip
	input ctrl_pkg::quad_t quad
);

	// Ack only drops once req was seen low
	ack_hold: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(ack) |-> !$past(req))
		else $error("evt_ack fell while evt_req was still high");

	one_stb: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(stb))
		else $error("More than one event strobe high in the same cycle");

	// AB output moves one bit per step
	quad_gray: assert property (@(posedge clk) disable iff (!rst_n)
		!$stable(quad) |-> $onehot(quad ^ $past(quad)))
		else $error("Quadrature output changed two bits at once");

endmodule

bind host_event_rx ctrl_asserts u_rx_asserts (
	.clk   (CLK_48M),
	.rst_n (rst_n),
	.req   (evt_req),
	.ack   (evt_ack),
	.stb   ({ev.key_stb, ev.mouse_stb, ev.dip_stb}),
	.quad  (2'b00)   // No AB output here
);

bind spinner_quad ctrl_asserts u_spin_asserts (
	.clk   (CLK_48M),
	.rst_n (rst_n),
	.req   (1'b0),
	.ack   (1'b0),
	.stb   ({ev.key_stb, ev.mouse_stb, ev.dip_stb}),
	.quad  (quad)
);

//--- tb/tb_ctrl_top.sv
/*
 * Player control front end testbench
 * Table of host events against expected cabinet lines,
 * DIP byte and spinner step counts
 */

`timescale 1ns/100ps

module tb_ctrl_top;
	import ctrl_pkg::*;

	localparam evt_kind_t EVT_SPARE = 2'd3;                  // Acked, no strobe
	localparam int HS_TIMEOUT   = 64;                        // Cycles per handshake wait
	localparam int QUIET_CYCLES = SPIN_STEP_CYCLES + 16;     // Longer than one step period
	localparam int SPIN_TIMEOUT = 40 * SPIN_STEP_CYCLES;

	typedef struct packed {
		evt_kind_t  kind;
		evt_data_t  data;
		joy_t       joy;
		logic [5:0] exp_n;     // service coin2 coin1 start2 start1 fire
		logic [7:0] exp_dip;
		logic       spin_chk;  // Count steps after this row
		int         exp_steps; // Net signed steps
	} row_t;

	logic       CLK_48M;
	logic       rst_n;
	logic       evt_req;
	evt_kind_t  evt_kind;
	evt_data_t  evt_data;
	logic       evt_ack;
	joy_t       joy;
	logic       btn_shot_n, start1_n, start2_n, coin1_n, coin2_n, service_n;
	logic [7:0] dip_sw;
	quad_t      quad;
	quad_t      quad_prev;
	logic [5:0] lines_n;    // Same order as exp_n

	row_t  rows[$];
	string names[$];
	int    errors    = 0;
	int    tests     = 0;
	int    failed    = 0;
	int    fwd_cnt   = 0;   // Monitor transition counts
	int    rev_cnt   = 0;
	logic  timed_out = 1'b0;

	ctrl_top u_ctrl_top (.*);

	assign lines_n = {service_n, coin2_n, coin1_n, start2_n, start1_n, btn_shot_n};

	always #5 CLK_48M = ~CLK_48M; // 10 ns period

	// Index along the forward AB cycle 00 10 11 01
	function automatic int gray_pos(input quad_t q);
		case (q)
			2'b00:   return 0;
			2'b10:   return 1;
			2'b11:   return 2;
			default: return 3;
		endcase
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("FAILED %s expected %0h actual %0h", name, exp, act);
			errors++;
		end
	endtask

	task automatic report(input string name, input int errs_before);
		tests++;
		if (errors != errs_before) begin
			failed++;
			$display("%-16s wrong", name);
		end else
			$display("%-16s ok", name);
	endtask

	// Poll ack on falling edges until it reaches the level
	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		while (evt_ack !== level && n < HS_TIMEOUT) begin
			@(negedge CLK_48M);
			n++;
		end
		if (evt_ack !== level) begin
			$display("Handshake stalled, evt_ack not %b after %0d cycles", level, HS_TIMEOUT);
			timed_out = 1'b1;
		end
	endtask

	task automatic send_event(input evt_kind_t kind, input evt_data_t data);
		@(negedge CLK_48M);
		evt_kind = kind;
		evt_data = data;
		evt_req  = 1'b1;
		wait_ack(1'b1);
		evt_req = 1'b0; // Still on a falling edge
		wait_ack(1'b0);
	endtask

	// Spinner done once quad holds longer than a step period
	task automatic wait_quiet();
		int    idle;
		int    n;
		quad_t last;
		idle = 0;
		n    = 0;
		last = quad;
		while (idle < QUIET_CYCLES && n < SPIN_TIMEOUT) begin
			@(negedge CLK_48M);
			idle = (quad === last) ? idle + 1 : 0;
			last = quad;
			n++;
		end
		if (idle < QUIET_CYCLES) begin
			$display("Spinner kept stepping for %0d cycles", SPIN_TIMEOUT);
			timed_out = 1'b1;
		end
	endtask

	////////////////////
	// Quadrature monitor
	////////////////////
	always @(negedge CLK_48M) begin
		if (rst_n === 1'b1 && quad !== quad_prev) begin
			if ($countones(quad ^ quad_prev) != 1) begin
				$display("Quadrature jumped from %b to %b in one step", quad_prev, quad);
				errors++;
			end else if (((gray_pos(quad) - gray_pos(quad_prev)) & 3) == 1)
				fwd_cnt++;  // Positive position drains this way
			else
				rev_cnt++;
		end
		quad_prev = quad;
	end

	task automatic add_row(input string name, input evt_kind_t kind, input evt_data_t data,
			input joy_t joy_w, input logic [5:0] exp_n, input logic [7:0] exp_dip,
			input logic chk, input int steps);
		rows.push_back('{kind, data, joy_w, exp_n, exp_dip, chk, steps});
		names.push_back(name);
	endtask

	////////////////////
	// Stimulus table
	////////////////////
	task automatic fill_table();
		add_row("fire_make",     EVT_KEY,   16'h0129, 10'h000, 6'b111110, 8'hFF, 0, 0);
		add_row("fire_break",    EVT_KEY,   16'h0029, 10'h000, 6'b111111, 8'hFF, 0, 0);
		add_row("start1_make",   EVT_KEY,   16'h0116, 10'h000, 6'b111101, 8'hFF, 0, 0);
		add_row("unmapped_make", EVT_KEY,   16'h0155, 10'h000, 6'b111101, 8'hFF, 0, 0);
		add_row("unmapped_brk",  EVT_KEY,   16'h0017, 10'h000, 6'b111101, 8'hFF, 0, 0);
		add_row("start1_break",  EVT_KEY,   16'h0016, 10'h000, 6'b111111, 8'hFF, 0, 0);
		add_row("start2_make",   EVT_KEY,   16'h011E, 10'h000, 6'b111011, 8'hFF, 0, 0);
		add_row("coin1_make",    EVT_KEY,   16'h012E, 10'h000, 6'b110011, 8'hFF, 0, 0);
		add_row("coin2_make",    EVT_KEY,   16'h0136, 10'h000, 6'b100011, 8'hFF, 0, 0);
		add_row("service_make",  EVT_KEY,   16'h0146, 10'h000, 6'b000011, 8'hFF, 0, 0);
		add_row("start2_break",  EVT_KEY,   16'h001E, 10'h000, 6'b000111, 8'hFF, 0, 0);
		add_row("coin1_break",   EVT_KEY,   16'h002E, 10'h000, 6'b001111, 8'hFF, 0, 0);
		add_row("coin2_break",   EVT_KEY,   16'h0036, 10'h000, 6'b011111, 8'hFF, 0, 0);
		add_row("service_break", EVT_KEY,   16'h0046, 10'h000, 6'b111111, 8'hFF, 0, 0);
		add_row("joy_fire",      EVT_SPARE, 16'h0000, 10'h010, 6'b111110, 8'hFF, 0, 0);
		add_row("joy_start1",    EVT_SPARE, 16'h0000, 10'h040, 6'b111101, 8'hFF, 0, 0);
		add_row("joy_coin1",     EVT_SPARE, 16'h0000, 10'h080, 6'b110111, 8'hFF, 0, 0);
		add_row("joy_start2",    EVT_SPARE, 16'h0000, 10'h100, 6'b111011, 8'hFF, 0, 0);
		add_row("joy_unused",    EVT_SPARE, 16'h0000, 10'h22F, 6'b111111, 8'hFF, 0, 0);
		add_row("mouse_left",    EVT_MOUSE, 16'h0001, 10'h000, 6'b111110, 8'hFF, 0, 0);
		add_row("mouse_button",  EVT_MOUSE, 16'h0002, 10'h000, 6'b111110, 8'hFF, 0, 0);
		add_row("mouse_release", EVT_MOUSE, 16'h0000, 10'h000, 6'b111111, 8'hFF, 0, 0);
		add_row("dip_a5",        EVT_DIP,   16'h00A5, 10'h000, 6'b111111, 8'h5A, 0, 0);
		add_row("spin_plus5",    EVT_MOUSE, 16'h0500, 10'h000, 6'b111111, 8'h5A, 1, 5);
		add_row("spin_minus7",   EVT_MOUSE, 16'hF900, 10'h000, 6'b111111, 8'h5A, 1, -7);
		add_row("spin_plus3",    EVT_MOUSE, 16'h0300, 10'h000, 6'b111111, 8'h5A, 0, 0);
		add_row("spin_minus3",   EVT_MOUSE, 16'hFD00, 10'h000, 6'b111111, 8'h5A, 1, 0);
	endtask

	initial begin
		int fwd0;
		int rev0;
		int errs0;
		int fwd_exp;
		int rev_exp;
		CLK_48M  = 1'b0;
		rst_n    = 1'b0;
		evt_req  = 1'b0;
		evt_kind = EVT_KEY;
		evt_data = '0;
		joy      = '0;
		fill_table();
		repeat (16) @(posedge CLK_48M);
		@(negedge CLK_48M);
		rst_n = 1'b1;
		@(negedge CLK_48M);

		errs0 = errors;  // Idle state straight out of reset
		check("reset lines", 6'h3F, lines_n);
		check("reset dip_sw", 8'hFF, dip_sw);
		check("reset quad", QUAD_RESET, quad);
		check("reset evt_ack", 1'b0, evt_ack);
		report("reset", errs0);

		fwd0 = 0;
		rev0 = 0;
		foreach (rows[i]) begin
			if (!timed_out) begin
				errs0 = errors;
				joy   = rows[i].joy;                  // Falling edge here
				send_event(rows[i].kind, rows[i].data);
				repeat (2) @(negedge CLK_48M);        // Output register latency
				check({names[i], " lines"}, rows[i].exp_n, lines_n);
				check({names[i], " dip_sw"}, rows[i].exp_dip, dip_sw);
				if (rows[i].spin_chk) begin
					wait_quiet();
					fwd_exp = (rows[i].exp_steps > 0) ? rows[i].exp_steps : 0;
					rev_exp = (rows[i].exp_steps < 0) ? -rows[i].exp_steps : 0;
					check({names[i], " fwd steps"}, fwd_exp, fwd_cnt - fwd0);
					check({names[i], " rev steps"}, rev_exp, rev_cnt - rev0);
					fwd0 = fwd_cnt; // Next spin window
					rev0 = rev_cnt;
				end
				report(names[i], errs0);
			end
		end

		$display("Summary %0d tests, %0d wrong, %0d errors", tests, failed, errors);
		if (errors == 0 && !timed_out)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- vlog.f
logic/ctrl_pkg.sv
logic/host_event_rx.sv
logic/key_decoder.sv
logic/cab_inputs.sv
logic/spinner_quad.sv
logic/ctrl_top.sv
tb/ctrl_asserts.sv
tb/tb_ctrl_top.sv
